// ==== p2mem.f ====
+incdir+rtl
rtl/p2mem_pkg.sv
rtl/vaddr_decode.sv
rtl/write_placement.sv
rtl/pivot_store.sv
rtl/read_return.sv
rtl/p2mem_top.sv
tests/tb_p2mem.sv

// ==== rtl/p2mem_defines.svh ====
`ifndef P2MEM_DEFINES_SVH
`define P2MEM_DEFINES_SVH

// data word width
`define P2_WIDTH 16

// valid flat addresses, all below this are in range
`define P2_NUMADDR 80

// pivot banks, need not be a power of two
`define P2_NUMVBNK 5

// rows per bank
`define P2_NUMVROW 16

// cycles from read sample to result
`define P2_READ_DELAY 2

`endif

// ==== rtl/p2mem_pkg.sv ====
`include "p2mem_defines.svh"

package p2mem_pkg;

  // flat address width, the encodings past NUMADDR are invalid
  localparam int BITADDR = $clog2(`P2_NUMADDR);

  // bank index width
  localparam int BITVBNK = $clog2(`P2_NUMVBNK);

  // row index width
  localparam int BITVROW = $clog2(`P2_NUMVROW);

endpackage

// ==== rtl/p2mem_top.sv ====
`timescale 1ns/10ps
`include "p2mem_defines.svh"

module p2mem_top (
  input  logic                            clk,
  input  logic                            rstvld,
  input  logic [1:0]                      vread,
  input  logic [1:0]                      vwrite,
  input  logic [2*p2mem_pkg::BITADDR-1:0] vaddr,
  input  logic [2*`P2_WIDTH-1:0]          vdin,
  output logic [1:0]                      vread_vld,
  output logic [2*`P2_WIDTH-1:0]          vdout,
  output logic [1:0]                      vread_err,
  output logic                            ready
);
  import p2mem_pkg::*;

  logic               rd1, wr1, bad1;
  logic               rd2, wr2, bad2;
  logic [BITVBNK-1:0] bank1, bank2;
  logic [BITVROW-1:0] row1, row2;

  logic [`P2_WIDTH-1:0] bank_dat1, cache_dat1;
  logic [`P2_WIDTH-1:0] bank_dat2, cache_dat2;
  logic                 map_vld1, map_vld2;
  logic [BITVBNK-1:0]   map_bank1, map_bank2;

  logic                 bwr1, bwr2, cwr;
  logic [BITVBNK-1:0]   bbank1, bbank2, cbank;
  logic [BITVROW-1:0]   brow1, brow2, crow;
  logic [`P2_WIDTH-1:0] bdin1, bdin2, cdin;
  logic                 mclr1, mclr2;
  logic [BITVROW-1:0]   mrow1, mrow2;

  vaddr_decode u_dec1 (
    .ready(ready), .op_read(vread[0]), .op_write(vwrite[0]),
    .addr(vaddr[BITADDR-1:0]),
    .rd(rd1), .wr(wr1), .bad(bad1), .bank(bank1), .row(row1)
  );

  vaddr_decode u_dec2 (
    .ready(ready), .op_read(vread[1]), .op_write(vwrite[1]),
    .addr(vaddr[2*BITADDR-1:BITADDR]),
    .rd(rd2), .wr(wr2), .bad(bad2), .bank(bank2), .row(row2)
  );

  write_placement u_place (
    .rd1(rd1), .wr1(wr1), .bank1(bank1), .row1(row1), .din1(vdin[`P2_WIDTH-1:0]),
    .rd2(rd2), .wr2(wr2), .bank2(bank2), .row2(row2),
    .din2(vdin[2*`P2_WIDTH-1:`P2_WIDTH]),
    .map_vld1(map_vld1), .map_bank1(map_bank1),
    .map_vld2(map_vld2), .map_bank2(map_bank2),
    .cache_dat1(cache_dat1), .cache_dat2(cache_dat2),
    .bwr1(bwr1), .bbank1(bbank1), .brow1(brow1), .bdin1(bdin1),
    .bwr2(bwr2), .bbank2(bbank2), .brow2(brow2), .bdin2(bdin2),
    .cwr(cwr), .crow(crow), .cdin(cdin), .cbank(cbank),
    .mclr1(mclr1), .mrow1(mrow1), .mclr2(mclr2), .mrow2(mrow2)
  );

  pivot_store u_store (
    .clk(clk), .rstvld(rstvld), .ready(ready),
    .bank1(bank1), .row1(row1), .bank_dat1(bank_dat1), .cache_dat1(cache_dat1),
    .map_vld1(map_vld1), .map_bank1(map_bank1),
    .bank2(bank2), .row2(row2), .bank_dat2(bank_dat2), .cache_dat2(cache_dat2),
    .map_vld2(map_vld2), .map_bank2(map_bank2),
    .bwr1(bwr1), .bbank1(bbank1), .brow1(brow1), .bdin1(bdin1),
    .bwr2(bwr2), .bbank2(bbank2), .brow2(brow2), .bdin2(bdin2),
    .cwr(cwr), .crow(crow), .cdin(cdin), .cbank(cbank),
    .mclr1(mclr1), .mrow1(mrow1), .mclr2(mclr2), .mrow2(mrow2)
  );

  read_return u_ret (
    .clk(clk), .rstvld(rstvld),
    .rd1(rd1), .bad1(bad1), .bank1(bank1), .bank_dat1(bank_dat1),
    .cache_dat1(cache_dat1), .map_vld1(map_vld1), .map_bank1(map_bank1),
    .rd2(rd2), .bad2(bad2), .bank2(bank2), .bank_dat2(bank_dat2),
    .cache_dat2(cache_dat2), .map_vld2(map_vld2), .map_bank2(map_bank2),
    .vread_vld(vread_vld), .vread_err(vread_err), .vdout(vdout)
  );

endmodule

// ==== rtl/pivot_store.sv ====
`timescale 1ns/10ps
`include "p2mem_defines.svh"

module pivot_store (
  input  logic                          clk,
  input  logic                          rstvld,
  output logic                          ready,
  input  logic [p2mem_pkg::BITVBNK-1:0] bank1,
  input  logic [p2mem_pkg::BITVROW-1:0] row1,
  output logic [`P2_WIDTH-1:0]          bank_dat1,
  output logic [`P2_WIDTH-1:0]          cache_dat1,
  output logic                          map_vld1,
  output logic [p2mem_pkg::BITVBNK-1:0] map_bank1,
  input  logic [p2mem_pkg::BITVBNK-1:0] bank2,
  input  logic [p2mem_pkg::BITVROW-1:0] row2,
  output logic [`P2_WIDTH-1:0]          bank_dat2,
  output logic [`P2_WIDTH-1:0]          cache_dat2,
  output logic                          map_vld2,
  output logic [p2mem_pkg::BITVBNK-1:0] map_bank2,
  input  logic                          bwr1,
  input  logic [p2mem_pkg::BITVBNK-1:0] bbank1,
  input  logic [p2mem_pkg::BITVROW-1:0] brow1,
  input  logic [`P2_WIDTH-1:0]          bdin1,
  input  logic                          bwr2,
  input  logic [p2mem_pkg::BITVBNK-1:0] bbank2,
  input  logic [p2mem_pkg::BITVROW-1:0] brow2,
  input  logic [`P2_WIDTH-1:0]          bdin2,
  input  logic                          cwr,
  input  logic [p2mem_pkg::BITVROW-1:0] crow,
  input  logic [`P2_WIDTH-1:0]          cdin,
  input  logic [p2mem_pkg::BITVBNK-1:0] cbank,
  input  logic                          mclr1,
  input  logic [p2mem_pkg::BITVROW-1:0] mrow1,
  input  logic                          mclr2,
  input  logic [p2mem_pkg::BITVROW-1:0] mrow2
);
  import p2mem_pkg::*;

  localparam logic [BITVROW:0] SWEEP_END = `P2_NUMVROW;

  logic [`P2_WIDTH-1:0] bank_mem [`P2_NUMVBNK][`P2_NUMVROW];
  logic [`P2_WIDTH-1:0] cache_mem [`P2_NUMVROW];
  logic                 map_vld_mem [`P2_NUMVROW];
  logic [BITVBNK-1:0]   map_bank_mem [`P2_NUMVROW];

  logic [BITVROW:0]   sweep_cnt;
  logic [BITVROW-1:0] sweep_row;
  logic               sweeping;

  assign sweep_row = sweep_cnt[BITVROW-1:0];
  assign sweeping = sweep_cnt < SWEEP_END;
  assign ready = !sweeping;

  // one row per cycle after reset
  always_ff @(posedge clk) begin
    if (rstvld) begin
      sweep_cnt <= '0;
    end else if (sweeping) begin
      sweep_cnt <= sweep_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (sweeping) begin
      for (int b = 0; b < `P2_NUMVBNK; b++) begin
        bank_mem[b][sweep_row] <= '0;
      end
      cache_mem[sweep_row] <= '0;
      map_vld_mem[sweep_row] <= 1'b0;
      map_bank_mem[sweep_row] <= '0;
    end else begin
      if (bwr1) begin
        bank_mem[bbank1][brow1] <= bdin1;
      end
      if (bwr2) begin
        bank_mem[bbank2][brow2] <= bdin2;
      end
      if (mclr1) begin
        map_vld_mem[mrow1] <= 1'b0;
      end
      if (mclr2) begin
        map_vld_mem[mrow2] <= 1'b0;
      end
      // last assignment, so a set beats a clear of the same row
      if (cwr) begin
        cache_mem[crow] <= cdin;
        map_vld_mem[crow] <= 1'b1;
        map_bank_mem[crow] <= cbank;
      end
    end
  end

  // lookups see the state before this edge's writes
  assign bank_dat1 = bank_mem[bank1][row1];
  assign cache_dat1 = cache_mem[row1];
  assign map_vld1 = map_vld_mem[row1];
  assign map_bank1 = map_bank_mem[row1];

  assign bank_dat2 = bank_mem[bank2][row2];
  assign cache_dat2 = cache_mem[row2];
  assign map_vld2 = map_vld_mem[row2];
  assign map_bank2 = map_bank_mem[row2];

endmodule

// ==== rtl/read_return.sv ====
`timescale 1ns/10ps
`include "p2mem_defines.svh"

module read_return (
  input  logic                          clk,
  input  logic                          rstvld,
  input  logic                          rd1,
  input  logic                          bad1,
  input  logic [p2mem_pkg::BITVBNK-1:0] bank1,
  input  logic [`P2_WIDTH-1:0]          bank_dat1,
  input  logic [`P2_WIDTH-1:0]          cache_dat1,
  input  logic                          map_vld1,
  input  logic [p2mem_pkg::BITVBNK-1:0] map_bank1,
  input  logic                          rd2,
  input  logic                          bad2,
  input  logic [p2mem_pkg::BITVBNK-1:0] bank2,
  input  logic [`P2_WIDTH-1:0]          bank_dat2,
  input  logic [`P2_WIDTH-1:0]          cache_dat2,
  input  logic                          map_vld2,
  input  logic [p2mem_pkg::BITVBNK-1:0] map_bank2,
  output logic [1:0]                    vread_vld,
  output logic [1:0]                    vread_err,
  output logic [2*`P2_WIDTH-1:0]        vdout
);

  localparam int DLY = `P2_READ_DELAY;

  logic                 hit1;
  logic                 hit2;
  logic [`P2_WIDTH-1:0] sel1;
  logic [`P2_WIDTH-1:0] sel2;

  logic [1:0]             vld_q [DLY];
  logic [1:0]             err_q [DLY];
  logic [2*`P2_WIDTH-1:0] dat_q [DLY];

  // cache holds the live word only when the map names this bank
  assign hit1 = map_vld1 && (map_bank1 == bank1);
  assign hit2 = map_vld2 && (map_bank2 == bank2);

  // error returns and idle slots carry zero data
  assign sel1 = rd1 ? (hit1 ? cache_dat1 : bank_dat1) : '0;
  assign sel2 = rd2 ? (hit2 ? cache_dat2 : bank_dat2) : '0;

  always_ff @(posedge clk) begin
    if (rstvld) begin
      for (int i = 0; i < DLY; i++) begin
        vld_q[i] <= '0;
        err_q[i] <= '0;
        dat_q[i] <= '0;
      end
    end else begin
      vld_q[0] <= {rd2, rd1};
      err_q[0] <= {bad2, bad1};
      dat_q[0] <= {sel2, sel1};
      for (int i = 1; i < DLY; i++) begin
        vld_q[i] <= vld_q[i-1];
        err_q[i] <= err_q[i-1];
        dat_q[i] <= dat_q[i-1];
      end
    end
  end

  assign vread_vld = vld_q[DLY-1];
  assign vread_err = err_q[DLY-1];
  assign vdout = dat_q[DLY-1];

endmodule

// ==== rtl/vaddr_decode.sv ====
`timescale 1ns/10ps
`include "p2mem_defines.svh"

module vaddr_decode (
  input  logic                         ready,
  input  logic                         op_read,
  input  logic                         op_write,
  input  logic [p2mem_pkg::BITADDR-1:0] addr,
  output logic                         rd,
  output logic                         wr,
  output logic                         bad,
  output logic [p2mem_pkg::BITVBNK-1:0] bank,
  output logic [p2mem_pkg::BITVROW-1:0] row
);
  import p2mem_pkg::*;

  localparam logic [BITADDR-1:0] NUM_ADDR = `P2_NUMADDR;
  localparam logic [BITADDR-1:0] NUM_BANK = `P2_NUMVBNK;

  logic               in_range;
  logic [BITADDR-1:0] bank_full;
  logic [BITADDR-1:0] row_full;

  assign in_range = addr < NUM_ADDR;

  // banks interleave on consecutive addresses
  assign bank_full = addr % NUM_BANK;
  assign row_full = addr / NUM_BANK;
  assign bank = bank_full[BITVBNK-1:0];
  assign row = row_full[BITVROW-1:0];

  assign rd = ready && op_read && in_range;
  assign wr = ready && op_write && in_range;
  // out of range writes just vanish
  assign bad = ready && op_read && !in_range;

endmodule

// ==== rtl/write_placement.sv ====
`timescale 1ns/10ps
`include "p2mem_defines.svh"

module write_placement (
  input  logic                          rd1,
  input  logic                          wr1,
  input  logic [p2mem_pkg::BITVBNK-1:0] bank1,
  input  logic [p2mem_pkg::BITVROW-1:0] row1,
  input  logic [`P2_WIDTH-1:0]          din1,
  input  logic                          rd2,
  input  logic                          wr2,
  input  logic [p2mem_pkg::BITVBNK-1:0] bank2,
  input  logic [p2mem_pkg::BITVROW-1:0] row2,
  input  logic [`P2_WIDTH-1:0]          din2,
  input  logic                          map_vld1,
  input  logic [p2mem_pkg::BITVBNK-1:0] map_bank1,
  input  logic                          map_vld2,
  input  logic [p2mem_pkg::BITVBNK-1:0] map_bank2,
  input  logic [`P2_WIDTH-1:0]          cache_dat1,
  input  logic [`P2_WIDTH-1:0]          cache_dat2,
  output logic                          bwr1,
  output logic [p2mem_pkg::BITVBNK-1:0] bbank1,
  output logic [p2mem_pkg::BITVROW-1:0] brow1,
  output logic [`P2_WIDTH-1:0]          bdin1,
  output logic                          bwr2,
  output logic [p2mem_pkg::BITVBNK-1:0] bbank2,
  output logic [p2mem_pkg::BITVROW-1:0] brow2,
  output logic [`P2_WIDTH-1:0]          bdin2,
  output logic                          cwr,
  output logic [p2mem_pkg::BITVROW-1:0] crow,
  output logic [`P2_WIDTH-1:0]          cdin,
  output logic [p2mem_pkg::BITVBNK-1:0] cbank,
  output logic                          mclr1,
  output logic [p2mem_pkg::BITVROW-1:0] mrow1,
  output logic                          mclr2,
  output logic [p2mem_pkg::BITVROW-1:0] mrow2
);
  import p2mem_pkg::*;

  logic               to_cache1;
  logic               to_cache2;
  logic               own_hit1;
  logic               own_hit2;
  logic               old_vld;
  logic [BITVBNK-1:0] old_bank;
  logic [`P2_WIDTH-1:0] old_dat;
  logic               evict;

  // bank busy: the other port reads it, or port 1 already writes it
  assign to_cache1 = wr1 && rd2 && (bank2 == bank1);
  assign to_cache2 = wr2 && (rd1 || wr1) && (bank1 == bank2);

  // map entry of the port's row points at the port's own bank
  assign own_hit1 = map_vld1 && (map_bank1 == bank1);
  assign own_hit2 = map_vld2 && (map_bank2 == bank2);

  // at most one port can lose its bank in a cycle
  assign cwr = to_cache1 || to_cache2;
  assign crow = to_cache1 ? row1 : row2;
  assign cdin = to_cache1 ? din1 : din2;
  assign cbank = to_cache1 ? bank1 : bank2;

  // word currently cached in the row about to be overwritten
  assign old_vld = to_cache1 ? map_vld1 : map_vld2;
  assign old_bank = to_cache1 ? map_bank1 : map_bank2;
  assign old_dat = to_cache1 ? cache_dat1 : cache_dat2;
  assign evict = cwr && old_vld && (old_bank != cbank);

  assign bwr1 = wr1 && !to_cache1;
  assign bbank1 = bank1;
  assign brow1 = row1;
  assign bdin1 = din1;

  // port 2's bank write is idle whenever a cache write happens,
  // so the evicted word always leaves through it
  always_comb begin
    if (evict) begin
      bwr2 = 1'b1;
      bbank2 = old_bank;
      brow2 = crow;
      bdin2 = old_dat;
    end else begin
      bwr2 = wr2 && !to_cache2;
      bbank2 = bank2;
      brow2 = row2;
      bdin2 = din2;
    end
  end

  // a pivot write makes the cached copy of its own bank stale
  assign mclr1 = bwr1 && own_hit1;
  assign mrow1 = row1;
  assign mclr2 = wr2 && !to_cache2 && own_hit2;
  assign mrow2 = row2;

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the p2mem testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary -Wno-fatal --top-module tb_p2mem -f p2mem.f -o tb_p2mem
./obj_dir/tb_p2mem > sim.log 2>&1
cat sim.log
if grep -q "^=== PASS ===$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// ==== tests/p2mem_stim.txt ====
# tag op1 addr1 data1 op2 addr2 data2, all hex, tag is the test number
# op 0 idle, 1 read, 2 write; a read's data column is the value it must return
1 1 00 0000 1 4f 0000
1 1 27 0000 1 0a 0000
1 1 3c 0000 0 00 0000
2 2 07 a5a5 0 00 0000
2 0 00 0000 2 12 1234
2 1 07 a5a5 1 12 1234
2 2 4e beef 2 01 0101
2 1 01 0101 1 4e beef
3 1 0c 0000 2 0c 5555
3 1 0c 5555 0 00 0000
3 2 11 6666 1 11 0000
3 0 00 0000 1 11 6666
3 1 07 a5a5 2 16 7777
3 1 16 7777 1 0c 5555
4 2 19 1111 2 1e 2222
4 2 23 aaaa 2 23 bbbb
4 2 06 3333 2 1f 4444
4 1 1e 2222 1 1f 4444
4 1 19 1111 1 23 bbbb
4 1 06 3333 1 07 a5a5
4 2 0f 8888 1 0a 0000
4 1 0f 8888 1 11 6666
4 2 0c 9999 0 00 0000
4 1 0c 9999 1 0d 0000
5 1 50 0000 1 7f 0000
5 2 50 dead 2 65 dead
5 1 00 0000 1 15 0000
5 2 60 ffff 1 4f 0000
5 1 10 0000 1 7e 0000

// ==== tests/tb_p2mem.sv ====
`timescale 1ns/10ps
`include "p2mem_defines.svh"

module tb_p2mem;
  import p2mem_pkg::*;

  localparam int W = `P2_WIDTH;
  localparam int AW = BITADDR;
  localparam int NUMADDR = `P2_NUMADDR;
  localparam int DLY = `P2_READ_DELAY;

  logic            clk;
  logic            rstvld;
  logic [1:0]      vread;
  logic [1:0]      vwrite;
  logic [2*AW-1:0] vaddr;
  logic [2*W-1:0]  vdin;
  logic [1:0]      vread_vld;
  logic [2*W-1:0]  vdout;
  logic [1:0]      vread_err;
  logic            ready;

  logic [W-1:0]    model [NUMADDR];
  logic [1:0]      cur_op [2];
  logic [AW-1:0]   cur_addr [2];
  logic [W-1:0]    cur_dat [2];
  // {err, vld, data} for every driven cycle
  logic [2*W+3:0]  exp_q [$];
  logic [31:0]     lfsr;
  int              errors;
  int              errors_before;
  int              reads_checked;

  p2mem_top u_dut (
    .clk(clk), .rstvld(rstvld), .vread(vread), .vwrite(vwrite), .vaddr(vaddr),
    .vdin(vdin), .vread_vld(vread_vld), .vdout(vdout), .vread_err(vread_err),
    .ready(ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
    $display("[FAIL] %s got %h expected %h at %0t", name, got, want, $time);
    errors++;
  endtask

  // one clock: check what returns now, then drive the next operations
  task automatic run_cycle(input bit from_file);
    logic [2*W+3:0] e;
    logic [2*W+3:0] x;
    @(negedge clk);
    if (exp_q.size() >= DLY) begin
      e = exp_q.pop_front();
      if (vread_vld !== e[2*W +: 2]) begin
        report_value("vread_vld", 32'(vread_vld), 32'(e[2*W +: 2]));
      end
      if (vread_err !== e[2*W+2 +: 2]) begin
        report_value("vread_err", 32'(vread_err), 32'(e[2*W+2 +: 2]));
      end
      for (int p = 0; p < 2; p++) begin
        if ((e[2*W+p] || e[2*W+2+p]) && vdout[p*W +: W] !== e[p*W +: W]) begin
          report_value($sformatf("vdout[%0d]", p), 32'(vdout[p*W +: W]), 32'(e[p*W +: W]));
        end
        reads_checked += int'(e[2*W+p]);
      end
    end
    x = '0;
    // reads see the memory as it was before this cycle's writes
    for (int p = 0; p < 2; p++) begin
      if (cur_op[p] == 2'd1 && cur_addr[p] >= NUMADDR) begin
        x[2*W+2+p] = 1'b1;
      end else if (cur_op[p] == 2'd1) begin
        x[2*W+p] = 1'b1;
        x[p*W +: W] = from_file ? cur_dat[p] : model[cur_addr[p]];
        if (from_file && cur_dat[p] !== model[cur_addr[p]]) begin
          $display("stim line expects %h at address %h but the model holds %h",
                   cur_dat[p], cur_addr[p], model[cur_addr[p]]);
          errors++;
        end
      end
    end
    // port 2 goes last so it wins a shared address
    for (int p = 0; p < 2; p++) begin
      if (cur_op[p] == 2'd2 && cur_addr[p] < NUMADDR) begin
        model[cur_addr[p]] = cur_dat[p];
      end
      vread[p] = cur_op[p] == 2'd1;
      vwrite[p] = cur_op[p] == 2'd2;
      vaddr[p*AW +: AW] = cur_addr[p];
      vdin[p*W +: W] = cur_dat[p];
    end
    exp_q.push_back(x);
  endtask

  // drain the read pipeline so the test's own reads land in its count
  task automatic finish_test(input int num);
    cur_op[0] = 2'd0;
    cur_op[1] = 2'd0;
    repeat (DLY) begin
      run_cycle(1'b0);
    end
    $display("test %0d finished with %0d errors", num, errors - errors_before);
    errors_before = errors;
  endtask

  // replay the directed stim file, one line per cycle
  task automatic play_stim_file(input int fd, output int last_tag);
    int    n;
    int    t, o1, a1, d1, o2, a2, d2;
    string line;
    last_tag = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line.substr(0, 0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h", t, o1, a1, d1, o2, a2, d2);
        if (n != 7) begin
          $display("stim line could not be parsed: %s", line);
          errors++;
        end else begin
          if (t != last_tag && last_tag != 0) begin
            finish_test(last_tag);
          end
          last_tag = t;
          cur_op[0] = o1[1:0];
          cur_addr[0] = a1[AW-1:0];
          cur_dat[0] = d1[W-1:0];
          cur_op[1] = o2[1:0];
          cur_addr[1] = a2[AW-1:0];
          cur_dat[1] = d2[W-1:0];
          run_cycle(1'b1);
        end
      end
    end
  endtask

  initial begin
    int fd;
    int n;
    int cur_tag;
    rstvld = 1'b1;
    vread = '0;
    vwrite = '0;
    vaddr = '0;
    vdin = '0;
    errors = 0;
    errors_before = 0;
    reads_checked = 0;
    cur_tag = 0;
    lfsr = 32'h1bceb805;
    for (int p = 0; p < 2; p++) begin
      cur_op[p] = 2'd0;
      cur_addr[p] = '0;
      cur_dat[p] = '0;
    end
    for (int a = 0; a < NUMADDR; a++) begin
      model[a] = '0;
    end
    repeat (5) begin
      @(negedge clk);
      if (ready !== 1'b0) begin
        report_value("ready", 32'(ready), 32'h0);
      end
      if (vread_vld !== 2'b00) begin
        report_value("vread_vld", 32'(vread_vld), 32'h0);
      end
      if (vread_err !== 2'b00) begin
        report_value("vread_err", 32'(vread_err), 32'h0);
      end
    end
    rstvld = 1'b0;
    // init sweep runs until ready
    n = 0;
    while (ready !== 1'b1 && n < 100) begin
      @(negedge clk);
      if (vread_vld !== 2'b00) begin
        report_value("vread_vld", 32'(vread_vld), 32'h0);
      end
      n++;
    end
    if (ready !== 1'b1) begin
      $display("timeout: ready still low 100 cycles after reset");
      $display("=== FAIL ===");
    end else begin
      fd = $fopen("tests/p2mem_stim.txt", "r");
      if (fd == 0) begin
        $display("could not open tests/p2mem_stim.txt");
        $display("=== FAIL ===");
      end else begin
        play_stim_file(fd, cur_tag);
        $fclose(fd);
        // read back every valid address, dropped writes must not show up
        for (int a = 0; a < NUMADDR; a += 2) begin
          cur_op[0] = 2'd1;
          cur_op[1] = 2'd1;
          cur_addr[0] = AW'(a);
          cur_addr[1] = AW'(a + 1);
          run_cycle(1'b0);
        end
        finish_test(cur_tag);
        // random traffic, addresses up to 95 so some fall out of range
        for (int i = 0; i < 200; i++) begin
          for (int p = 0; p < 2; p++) begin
            cur_op[p] = 2'(rand_bits(2) % 3);
            cur_addr[p] = AW'(rand_bits(7) % 96);
            cur_dat[p] = W'(rand_bits(W));
          end
          run_cycle(1'b0);
        end
        finish_test(6);
        $display("tests 6, reads checked %0d, errors %0d", reads_checked, errors);
        if (errors == 0) begin
          $display("=== PASS ===");
        end else begin
          $display("=== FAIL ===");
        end
      end
    end
    $finish;
  end

endmodule
